// ==== hdl/axi_mem_pkg.sv ====
// shared widths, memory depth, burst and response codes, command and memory port structs
`default_nettype none

package axi_mem_pkg;

  ////////////////////////////////////////
  // bus and field widths
  ////////////////////////////////////////

  localparam int addr_w = 32;  // byte address
  localparam int data_w = 32;  // one beat
  localparam int id_w   = 4;   // transaction tag
  localparam int len_w  = 4;   // beats minus one
  localparam int size_w = 3;   // log2 of bytes per beat
  localparam int burst_w = 2;
  localparam int resp_w  = 2;
  localparam int byte_w  = 8;
  localparam int lanes   = data_w / byte_w;  // byte lanes per word

  ////////////////////////////////////////
  // memory geometry
  ////////////////////////////////////////

  localparam int mem_bytes  = 128;
  localparam int mem_addr_w = $clog2(mem_bytes);  // 7 bits

  ////////////////////////////////////////
  // burst and response encodings
  ////////////////////////////////////////

  localparam logic [burst_w-1:0] burst_fixed = 2'b00;  // same address every beat
  localparam logic [burst_w-1:0] burst_incr  = 2'b01;  // step by beat size
  localparam logic [burst_w-1:0] burst_wrap  = 2'b10;  // step, wrap at block edge

  localparam logic [resp_w-1:0] resp_okay   = 2'b00;
  localparam logic [resp_w-1:0] resp_slverr = 2'b10;  // bad size or wrap length
  localparam logic [resp_w-1:0] resp_decerr = 2'b11;  // start address off the map

  localparam logic [size_w-1:0] max_size = 3'd2;  // 4 bytes per beat at most

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  // address channel payload, same for AW and AR
  typedef struct packed {
    logic [id_w-1:0]    id;
    logic [addr_w-1:0]  addr;   // start byte address
    logic [len_w-1:0]   len;    // beats minus one
    logic [size_w-1:0]  size;
    logic [burst_w-1:0] burst;
  } burst_cmd_t;

  // strobed write into the byte RAM
  typedef struct packed {
    logic                  en;
    logic [mem_addr_w-1:0] addr;  // lane 0 byte address
    logic [data_w-1:0]     data;
    logic [lanes-1:0]      strb;
  } mem_wr_t;

  // combinational read port of the byte RAM
  typedef struct packed {
    logic [mem_addr_w-1:0] addr;  // lane 0 byte address
    logic [data_w-1:0]     data;  // byte addr+k in lane k
  } mem_rd_t;

endpackage

`default_nettype wire

// ==== hdl/axi_burst_step.sv ====
// axi_burst_step: next beat address for FIXED, INCR and WRAP bursts and the burst legality check
`default_nettype none

module axi_burst_step (
  input  wire [axi_mem_pkg::addr_w-1:0] addr,
  input  wire axi_mem_pkg::burst_cmd_t  cmd,
  output logic [axi_mem_pkg::addr_w-1:0] next_addr,
  output logic                           legal
);
  import axi_mem_pkg::*;

  logic [addr_w-1:0] step;       // bytes per beat
  logic [addr_w-1:0] blk_bytes;  // wrap block size
  logic [addr_w-1:0] wrap_mask;
  logic [addr_w-1:0] incr_addr;
  logic [addr_w-1:0] wrap_addr;
  logic              size_ok;
  logic              wrap_len_ok;

  assign step      = addr_w'(1) << cmd.size;
  assign blk_bytes = (addr_w'(cmd.len) + addr_w'(1)) << cmd.size;
  assign wrap_mask = blk_bytes - addr_w'(1);
  assign incr_addr = addr + step;

  // block base stays, offset rolls over inside the block
  assign wrap_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);

  always_comb begin
    unique case (cmd.burst)
      burst_fixed: next_addr = addr;
      burst_incr:  next_addr = incr_addr;
      burst_wrap:  next_addr = wrap_addr;
      default:     next_addr = addr;  // reserved code, held
    endcase
  end

  assign size_ok     = (cmd.size <= max_size);
  assign wrap_len_ok = (cmd.len == 4'd1) || (cmd.len == 4'd3) ||
                       (cmd.len == 4'd7) || (cmd.len == 4'd15);  // 2, 4, 8, 16 beats

  always_comb begin
    legal = size_ok;
    if (cmd.burst == burst_wrap && !wrap_len_ok) begin
      legal = 1'b0;
    end
    if (cmd.burst != burst_fixed && cmd.burst != burst_incr && cmd.burst != burst_wrap) begin
      legal = 1'b0;  // reserved burst type
    end
  end

endmodule

`default_nettype wire

// ==== hdl/axi_write_engine.sv ====
// axi_write_engine: AW/W/B channel FSM that produces strobed writes into the byte RAM
`default_nettype none

module axi_write_engine (
  input  wire                             clk,
  input  wire                             resetn,
  input  wire axi_mem_pkg::burst_cmd_t    aw_cmd,
  input  wire                             awvalid,
  output logic                            awready,
  input  wire                             wvalid,
  output logic                            wready,
  input  wire [axi_mem_pkg::data_w-1:0]   wdata,
  input  wire [axi_mem_pkg::lanes-1:0]    wstrb,
  input  wire                             wlast,   // framing only, beat count ends the burst
  output logic                            bvalid,
  input  wire                             bready,
  output logic [axi_mem_pkg::id_w-1:0]    bid,
  output logic [axi_mem_pkg::resp_w-1:0]  bresp,
  output axi_mem_pkg::mem_wr_t            mem_wr
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    st_addr,  // waiting for AW
    st_data,  // taking W beats
    st_resp   // holding B until bready
  } wr_state_t;

  wr_state_t         state;
  burst_cmd_t        cmd_q;
  logic [addr_w-1:0] cur_addr;   // address of the beat being taken
  logic [addr_w-1:0] next_addr;
  logic [len_w-1:0]  beat_cnt;
  logic              legal;
  logic [resp_w-1:0] resp_calc;
  logic [resp_w-1:0] resp_q;
  logic              aw_fire;
  logic              w_fire;
  logic              b_fire;
  logic              last_beat;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  assign awready   = (state == st_addr);
  assign wready    = (state == st_data);
  assign bvalid    = (state == st_resp);
  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign b_fire    = bvalid && bready;
  assign last_beat = (beat_cnt == cmd_q.len);
  assign bid       = cmd_q.id;
  assign bresp     = resp_q;

  axi_burst_step u_burst_step (
    .addr      (cur_addr),
    .cmd       (cmd_q),
    .next_addr (next_addr),
    .legal     (legal)
  );

  // slverr wins over decerr, both depend only on the latched command
  always_comb begin
    if (!legal) begin
      resp_calc = resp_slverr;
    end else if (cmd_q.addr >= addr_w'(mem_bytes)) begin
      resp_calc = resp_decerr;
    end else begin
      resp_calc = resp_okay;
    end
  end

  ////////////////////////////////////////
  // FSM and beat counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= st_addr;
      beat_cnt <= '0;
    end else begin
      unique case (state)
        st_addr: begin
          if (aw_fire) begin
            state    <= st_data;
            beat_cnt <= '0;
          end
        end
        st_data: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + len_w'(1);
            if (last_beat) begin
              state <= st_resp;  // B goes out next cycle
            end
          end
        end
        st_resp: begin
          if (b_fire) begin
            state <= st_addr;
          end
        end
        default: state <= st_addr;
      endcase
    end
  end

  // command, beat address and response
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      cmd_q    <= aw_cmd;
      cur_addr <= aw_cmd.addr;
    end
    if (w_fire) begin
      cur_addr <= next_addr;
      if (last_beat) begin
        resp_q <= resp_calc;
      end
    end
  end

  // RAM write on the W handshake edge, only for clean bursts
  always_comb begin
    mem_wr.en   = w_fire && (resp_calc == resp_okay);
    mem_wr.addr = cur_addr[mem_addr_w-1:0];  // modulo memory size
    mem_wr.data = wdata;
    mem_wr.strb = wstrb;
  end

endmodule

`default_nettype wire

// ==== hdl/axi_byte_ram.sv ====
// axi_byte_ram: 128-byte memory, four-lane strobed write port and four-lane combinational read
`default_nettype none

module axi_byte_ram (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire axi_mem_pkg::mem_wr_t         mem_wr,
  input  wire [axi_mem_pkg::mem_addr_w-1:0] mem_rd_addr,
  output logic [axi_mem_pkg::data_w-1:0]    mem_rd_data
);
  import axi_mem_pkg::*;

  logic [byte_w-1:0]     mem [mem_bytes];
  logic [mem_addr_w-1:0] wr_lane_addr [lanes];  // base plus lane, wraps at 128
  logic [mem_addr_w-1:0] rd_lane_addr [lanes];

  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      wr_lane_addr[k] = mem_wr.addr + mem_addr_w'(k);
      rd_lane_addr[k] = mem_rd_addr + mem_addr_w'(k);
    end
  end

  // whole array starts at zero
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < mem_bytes; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_wr.en) begin
      for (int k = 0; k < lanes; k++) begin
        if (mem_wr.strb[k]) begin
          mem[wr_lane_addr[k]] <= mem_wr.data[k*byte_w +: byte_w];
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      mem_rd_data[k*byte_w +: byte_w] = mem[rd_lane_addr[k]];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/axi_read_engine.sv ====
// axi_read_engine: AR/R channel FSM that walks burst addresses and returns registered beats
`default_nettype none

module axi_read_engine (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire axi_mem_pkg::burst_cmd_t      ar_cmd,
  input  wire                               arvalid,
  output logic                              arready,
  output logic                              rvalid,
  input  wire                               rready,
  output logic [axi_mem_pkg::id_w-1:0]      rid,
  output logic [axi_mem_pkg::data_w-1:0]    rdata,
  output logic [axi_mem_pkg::resp_w-1:0]    rresp,
  output logic                              rlast,
  output logic [axi_mem_pkg::mem_addr_w-1:0] mem_rd_addr,
  input  wire [axi_mem_pkg::data_w-1:0]     mem_rd_data
);
  import axi_mem_pkg::*;

  typedef enum logic {
    st_idle,  // waiting for AR
    st_beat   // a beat is on R
  } rd_state_t;

  rd_state_t         state;
  burst_cmd_t        cmd_q;
  burst_cmd_t        step_cmd;   // incoming command in idle, latched one after
  logic [addr_w-1:0] cur_addr;   // address of the beat on R
  logic [addr_w-1:0] next_addr;
  logic [addr_w-1:0] beat_addr;  // address of the beat to load
  logic [len_w-1:0]  beat_cnt;
  logic              legal;
  logic [resp_w-1:0] resp_calc;
  logic [data_w-1:0] lane_mask;
  logic [data_w-1:0] beat_data;
  logic              ar_fire;
  logic              r_fire;

  assign arready  = (state == st_idle);
  assign rvalid   = (state == st_beat);
  assign ar_fire  = arvalid && arready;
  assign r_fire   = rvalid && rready;
  assign rid      = cmd_q.id;
  assign step_cmd = (state == st_idle) ? ar_cmd : cmd_q;
  assign beat_addr   = (state == st_idle) ? ar_cmd.addr : next_addr;
  assign mem_rd_addr = beat_addr[mem_addr_w-1:0];

  axi_burst_step u_burst_step (
    .addr      (cur_addr),
    .cmd       (step_cmd),
    .next_addr (next_addr),
    .legal     (legal)
  );

  always_comb begin
    if (!legal) begin
      resp_calc = resp_slverr;
    end else if (step_cmd.addr >= addr_w'(mem_bytes)) begin
      resp_calc = resp_decerr;
    end else begin
      resp_calc = resp_okay;
    end
  end

  // keep the low 2^size lanes, error beats read as zero
  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      lane_mask[k*byte_w +: byte_w] = (k < (1 << step_cmd.size)) ? {byte_w{1'b1}} : '0;
    end
    beat_data = (resp_calc == resp_okay) ? (mem_rd_data & lane_mask) : '0;
  end

  ////////////////////////////////////////
  // FSM, beat counter and last flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= st_idle;
      beat_cnt <= '0;
      rlast    <= 1'b0;
    end else begin
      unique case (state)
        st_idle: begin
          if (ar_fire) begin
            state    <= st_beat;
            beat_cnt <= '0;
            rlast    <= (ar_cmd.len == '0);  // single-beat burst
          end
        end
        st_beat: begin
          if (r_fire) begin
            if (rlast) begin
              state <= st_idle;
              rlast <= 1'b0;
            end else begin
              beat_cnt <= beat_cnt + len_w'(1);
              rlast    <= (beat_cnt + len_w'(1) == cmd_q.len);
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // beat payload only moves on a handshake, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      cmd_q <= ar_cmd;
      rresp <= resp_calc;
    end
    if (ar_fire || (r_fire && !rlast)) begin
      cur_addr <= beat_addr;
      rdata    <= beat_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/axi_mem_top.sv ====
// axi_mem_top: AXI-style memory slave, write engine, byte RAM and read engine
`default_nettype none

module axi_mem_top (
  input  wire                               clk,
  input  wire                               resetn,
  // write address
  input  wire axi_mem_pkg::burst_cmd_t      aw_cmd,
  input  wire                               awvalid,
  output logic                              awready,
  // write data
  input  wire [axi_mem_pkg::data_w-1:0]     wdata,
  input  wire [axi_mem_pkg::lanes-1:0]      wstrb,
  input  wire                               wlast,
  input  wire                               wvalid,
  output logic                              wready,
  // write response
  output logic [axi_mem_pkg::id_w-1:0]      bid,
  output logic [axi_mem_pkg::resp_w-1:0]    bresp,
  output logic                              bvalid,
  input  wire                               bready,
  // read address
  input  wire axi_mem_pkg::burst_cmd_t      ar_cmd,
  input  wire                               arvalid,
  output logic                              arready,
  // read data
  output logic [axi_mem_pkg::id_w-1:0]      rid,
  output logic [axi_mem_pkg::data_w-1:0]    rdata,
  output logic [axi_mem_pkg::resp_w-1:0]    rresp,
  output logic                              rlast,
  output logic                              rvalid,
  input  wire                               rready
);
  import axi_mem_pkg::*;

  mem_wr_t mem_wr;
  mem_rd_t mem_rd;

  axi_write_engine u_write_engine (
    .clk     (clk),
    .resetn  (resetn),
    .aw_cmd  (aw_cmd),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .bvalid  (bvalid),
    .bready  (bready),
    .bid     (bid),
    .bresp   (bresp),
    .mem_wr  (mem_wr)
  );

  axi_byte_ram u_byte_ram (
    .clk         (clk),
    .resetn      (resetn),
    .mem_wr      (mem_wr),
    .mem_rd_addr (mem_rd.addr),
    .mem_rd_data (mem_rd.data)
  );

  axi_read_engine u_read_engine (
    .clk         (clk),
    .resetn      (resetn),
    .ar_cmd      (ar_cmd),
    .arvalid     (arvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rready      (rready),
    .rid         (rid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rlast       (rlast),
    .mem_rd_addr (mem_rd.addr),
    .mem_rd_data (mem_rd.data)
  );

endmodule

`default_nettype wire

// ==== test/axi_mem_asserts.sv ====
// response hold under back-pressure and last-beat framing checks, bound to both engines
`default_nettype none

module axi_mem_asserts (
  input wire                          clk,
  input wire                          resetn,
  input wire                          valid,      // response channel valid
  input wire                          ready,
  input wire [63:0]                   payload,    // response fields, zero padded
  input wire                          beat_fire,  // data beat handshake
  input wire                          last_flag,  // wlast or rlast
  input wire [axi_mem_pkg::len_w-1:0] burst_len   // latched command len
);
  import axi_mem_pkg::*;

  logic [len_w-1:0] beat_count;  // handshakes seen in the current burst

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      beat_count <= '0;
    end else if (beat_fire) begin
      beat_count <= (beat_count == burst_len) ? '0 : beat_count + len_w'(1);
    end
  end

  // a stalled response keeps valid and its fields
  a_hold_stalled: assert property (
    @(posedge clk) disable iff (!resetn)
    valid && !ready |=> valid && $stable(payload)
  ) else $error("response valid or payload changed while ready was low");

  // last flag exactly on beat len+1
  a_last_beat: assert property (
    @(posedge clk) disable iff (!resetn)
    beat_fire |-> (last_flag == (beat_count == burst_len))
  ) else $error("last flag does not match the counted final beat");

endmodule

bind axi_write_engine axi_mem_asserts u_write_asserts (
  .clk       (clk),
  .resetn    (resetn),
  .valid     (bvalid),
  .ready     (bready),
  .payload   (64'({bid, bresp})),
  .beat_fire (w_fire),
  .last_flag (wlast),
  .burst_len (cmd_q.len)
);

bind axi_read_engine axi_mem_asserts u_read_asserts (
  .clk       (clk),
  .resetn    (resetn),
  .valid     (rvalid),
  .ready     (rready),
  .payload   (64'({rid, rdata, rresp, rlast})),
  .beat_fire (r_fire),
  .last_flag (rlast),
  .burst_len (cmd_q.len)
);

`default_nettype wire

// ==== test/tb_axi_mem.sv ====
// tb_axi_mem: clock, reset, trace reader, channel drivers, value checker, timeout and summary
`default_nettype none

module tb_axi_mem;
  import axi_mem_pkg::*;

  localparam int trace_depth = 256;

  logic              clk = 1'b0;
  logic              resetn;
  burst_cmd_t        aw_cmd;
  logic              awvalid;
  logic              awready;
  logic [data_w-1:0] wdata;
  logic [lanes-1:0]  wstrb;
  logic              wlast;
  logic              wvalid;
  logic              wready;
  logic [id_w-1:0]   bid;
  logic [resp_w-1:0] bresp;
  logic              bvalid;
  logic              bready;
  burst_cmd_t        ar_cmd;
  logic              arvalid;
  logic              arready;
  logic [id_w-1:0]   rid;
  logic [data_w-1:0] rdata;
  logic [resp_w-1:0] rresp;
  logic              rlast;
  logic              rvalid;
  logic              rready;

  logic [31:0] trace [trace_depth];
  int          ptr;
  int          n_tests;
  int          n_failed;
  int          n_errors;
  int          test_errors;
  string       cur_test;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;  // zero until the trace is sized

  axi_mem_top u_axi_mem_top (
    .clk     (clk),
    .resetn  (resetn),
    .aw_cmd  (aw_cmd),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .ar_cmd  (ar_cmd),
    .arvalid (arvalid),
    .arready (arready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: the DUT did not finish the trace within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // trace helpers and checker
  ////////////////////////////////////////

  // record head: kind, id, addr, len, size, burst, hold
  function automatic burst_cmd_t load_cmd(input int base);
    burst_cmd_t cmd;
    cmd.id    = trace[base+1][id_w-1:0];
    cmd.addr  = trace[base+2];
    cmd.len   = trace[base+3][len_w-1:0];
    cmd.size  = trace[base+4][size_w-1:0];
    cmd.burst = trace[base+5][burst_w-1:0];
    return cmd;
  endfunction

  function automatic int count_beats();
    int p;
    int beats;
    int n;
    p     = 0;
    beats = 0;
    while (p < trace_depth && (trace[p] === 32'd1 || trace[p] === 32'd2)) begin
      n     = trace[p+3] + 1;
      beats = beats + n;
      p     = (trace[p] === 32'd1) ? p + 8 + 2*n : p + 8 + n;  // write has data and strobe
    end
    return beats;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
      test_errors = test_errors + 1;
      n_errors    = n_errors + 1;
    end
  endtask

  ////////////////////////////////////////
  // channel drivers
  ////////////////////////////////////////

  task automatic run_write();
    burst_cmd_t             cmd;
    int                     hold;
    int                     n;
    logic [id_w+resp_w-1:0] b_snap;
    cmd  = load_cmd(ptr);
    hold = trace[ptr+6];
    n    = cmd.len + 1;
    ptr  = ptr + 7;
    aw_cmd  <= cmd;
    awvalid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!awready);
    awvalid <= 1'b0;
    for (int i = 0; i < n; i++) begin
      wdata  <= trace[ptr + 2*i];
      wstrb  <= trace[ptr + 2*i + 1][lanes-1:0];
      wlast  <= (i == n - 1);
      wvalid <= 1'b1;
      do begin
        @(posedge clk);
      end while (!wready);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    ptr = ptr + 2*n;
    do begin
      @(posedge clk);
    end while (!bvalid);
    b_snap = {bid, bresp};
    repeat (hold) begin  // response must sit still while bready is low
      @(posedge clk);
      check_value("bvalid held", 64'd1, 64'(bvalid));
      check_value("b payload held", 64'(b_snap), 64'({bid, bresp}));
    end
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    check_value("bid", 64'(cmd.id), 64'(bid));
    check_value("bresp", 64'(trace[ptr]), 64'(bresp));
    ptr = ptr + 1;
  endtask

  task automatic run_read();
    burst_cmd_t                    cmd;
    int                            hold;
    int                            n;
    logic [resp_w-1:0]             exp_resp;
    logic [id_w+data_w+resp_w:0]   r_snap;
    cmd      = load_cmd(ptr);
    hold     = trace[ptr+6];
    n        = cmd.len + 1;
    exp_resp = trace[ptr+7][resp_w-1:0];
    ptr      = ptr + 8;
    ar_cmd  <= cmd;
    arvalid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!arready);
    arvalid <= 1'b0;
    if (hold == 0) begin
      rready <= 1'b1;
    end else begin
      do begin
        @(posedge clk);
      end while (!rvalid);
      r_snap = {rid, rdata, rresp, rlast};
      repeat (hold) begin
        @(posedge clk);
        check_value("rvalid held", 64'd1, 64'(rvalid));
        check_value("r payload held", 64'(r_snap), 64'({rid, rdata, rresp, rlast}));
      end
      rready <= 1'b1;
    end
    for (int i = 0; i < n; i++) begin
      do begin
        @(posedge clk);
      end while (!rvalid);  // rready is high, so this edge takes a beat
      check_value($sformatf("rdata beat %0d", i), 64'(trace[ptr+i]), 64'(rdata));
      check_value("rresp", 64'(exp_resp), 64'(rresp));
      check_value("rid", 64'(cmd.id), 64'(rid));
      check_value($sformatf("rlast beat %0d", i), 64'(i == n - 1), 64'(rlast));
    end
    rready <= 1'b0;
    ptr = ptr + n;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    resetn   = 1'b0;
    aw_cmd   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wlast    = 1'b0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    ar_cmd   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    ptr      = 0;
    n_tests  = 0;
    n_failed = 0;
    n_errors = 0;
    $readmemh("test/axi_mem_trace.txt", trace);
    cycle_limit = 20 * count_beats() + 100;
    repeat (2) @(posedge clk);
    resetn <= 1'b1;
    if (trace[0] === 32'bx) begin
      $display("the trace file could not be read, no transactions were run");
      n_errors = n_errors + 1;
    end
    while (ptr < trace_depth && (trace[ptr] === 32'd1 || trace[ptr] === 32'd2)) begin
      test_errors = 0;
      cur_test = $sformatf("%s_%0d_id%0h", (trace[ptr] === 32'd1) ? "write" : "read",
                           n_tests, trace[ptr+1][id_w-1:0]);
      if (trace[ptr] === 32'd1) begin
        run_write();
      end else begin
        run_read();
      end
      n_tests = n_tests + 1;
      if (test_errors == 0) begin
        $display("%s ok", cur_test);
      end else begin
        n_failed = n_failed + 1;
        $display("%s had %0d mismatches", cur_test, test_errors);
      end
    end
    $display("tests %0d, failed %0d, mismatches %0d", n_tests, n_failed, n_errors);
    if (n_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/axi_mem_trace.txt ====
// columns: kind (1 write, 2 read), id, start addr, len, size, burst, ready hold cycles
// write then gives wdata and wstrb per beat and bresp; read gives rresp then rdata per beat
// incr write and read back with 4-byte beats
1 1 00000000 3 2 1 0  11223344 f 55667788 f 99aabbcc f ddeeff00 f  0
2 2 00000000 3 2 1 0  0  11223344 55667788 99aabbcc ddeeff00
// narrow strobed writes, read back as words
1 3 00000020 1 0 1 0  000000a5 1 0000005a 1  0
1 4 00000024 1 1 1 0  0000beef 3 0000cafe 1  0
2 5 00000020 2 2 1 0  0  00005aa5 00febeef 00000000
// fixed burst keeps the last beat, read held off by rready
1 6 00000030 2 2 0 0  01010101 f 02020202 f 03030303 f  0
2 7 00000030 2 2 0 3  0  03030303 03030303 03030303
// wrap inside the 0x40 block, bready held off
1 8 00000048 3 2 2 2  a0000001 f a0000002 f a0000003 f a0000004 f  0
2 9 00000048 3 2 2 0  0  a0000001 a0000002 a0000003 a0000004
2 a 00000040 3 2 1 0  0  a0000003 a0000004 a0000001 a0000002
// decode and size errors, memory left as it was
1 b 00000080 1 2 1 0  ffffffff f ffffffff f  3
1 c 00000000 0 3 1 0  ffffffff f  2
2 d 00000080 1 2 1 0  3  00000000 00000000
2 e 00000000 2 3 1 0  2  00000000 00000000 00000000
2 f 00000000 1 2 1 0  0  11223344 55667788
// end of trace
0

// ==== src.f ====
hdl/axi_mem_pkg.sv
hdl/axi_burst_step.sv
hdl/axi_write_engine.sv
hdl/axi_byte_ram.sv
hdl/axi_read_engine.sv
hdl/axi_mem_top.sv
test/axi_mem_asserts.sv
test/tb_axi_mem.sv
